//--- vlog.f
logic/mouse_isa_pkg.sv
logic/mouse_bus_pkg.sv
logic/mouse_bus_if.sv
logic/mouse_decode.sv
logic/mouse_execute.sv
logic/mouse_control.sv
logic/mouse_retire.sv
logic/mouse_top.sv
tb/tb_mouse.sv

//--- run.sh
#!/bin/sh
# build the mouse testbench with verilator and run it
# exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --Mdir obj_dir \
     --top-module tb_mouse -f vlog.f -o sim_mouse; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_mouse
status=$?

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
fi

exit "$status"

//--- tb/tb_mouse.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mouse;
  import mouse_isa_pkg::*;

  localparam logic [31:0] RESET_ADR = 32'h0000_0200;  // program start
  localparam logic [31:0] GPR_ADR   = 32'h0000_0f80;  // register file, top of memory
  localparam int          N_INS     = 400;  // program words, last is the loop
  localparam int          N_REC     = 300;
  localparam int          TMO       = 200;  // cycles per wait

  logic        tcb = 1'b0;
  logic        rst;
  logic        bus_vld;
  logic        bus_wen;
  logic [31:0] bus_adr;
  logic [31:0] bus_wdt;
  logic        bus_rdy;
  logic [31:0] bus_rdt;
  logic        ret_vld;
  logic [31:0] ret_adr;
  logic [31:0] ret_ins;
  logic        ret_wbu_vld;
  logic [4:0]  ret_wbu_idx;
  logic [31:0] ret_wbu_dat;
  logic        ret_lsu_vld;
  logic        ret_lsu_wen;
  logic [31:0] ret_lsu_adr;
  logic [31:0] ret_lsu_dat;

  logic [31:0] mem     [0:1023];  // bus side, 4 KiB
  logic [31:0] ref_mem [0:1023];  // model side copy
  logic [31:0] regs    [0:31];
  logic [31:0] seed = 32'hee8662c3;
  logic [31:0] pc_m;
  // expected record
  logic [31:0] exp_adr;
  logic [31:0] exp_ins;
  logic        exp_wbu_vld;
  logic [4:0]  exp_wbu_idx;
  logic [31:0] exp_wbu_dat;
  logic        exp_lsu_vld;
  logic        exp_lsu_wen;
  logic [31:0] exp_lsu_adr;
  logic [31:0] exp_lsu_dat;

  mouse_top #(.RESET_ADR (RESET_ADR), .GPR_ADR (GPR_ADR)) dut0 (
    .tcb (tcb), .rst (rst),
    .bus_vld (bus_vld), .bus_wen (bus_wen), .bus_adr (bus_adr), .bus_wdt (bus_wdt),
    .bus_rdy (bus_rdy), .bus_rdt (bus_rdt),
    .ret_vld (ret_vld), .ret_adr (ret_adr), .ret_ins (ret_ins),
    .ret_wbu_vld (ret_wbu_vld), .ret_wbu_idx (ret_wbu_idx), .ret_wbu_dat (ret_wbu_dat),
    .ret_lsu_vld (ret_lsu_vld), .ret_lsu_wen (ret_lsu_wen),
    .ret_lsu_adr (ret_lsu_adr), .ret_lsu_dat (ret_lsu_dat)
  );

  initial begin
    forever #10 tcb = ~tcb;  // 20 ns period
  end

////////////////////
// helpers
////////////////////

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // lcg, numerical recipes constants
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // every address bit feeds the word
  function automatic logic [31:0] fill_word(input logic [9:0] widx);
    logic [31:0] a;
    a = {20'd0, widx, 2'b00};
    return (a * 32'h9e37_79b1) ^ {~a[15:0], a[15:0]};
  endfunction

  // one random instruction for a program slot, x0..x7 only
  function automatic logic [31:0] random_ins(input int slot);
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] ofs;
    logic [12:0] bof;
    int          k;
    int          room;
    r    = next_rand();
    r2   = next_rand();
    rd   = {2'b00, r[18:16]};
    rs1  = {2'b00, r[21:19]};
    rs2  = r[22] ? rs1 : {2'b00, r[25:23]};  // equal operands now and then
    ofs  = {4'h1, r2[27:22], 2'b00};  // data window 0x100..0x1fc
    room = N_INS - 1 - slot;  // words left before the loop
    k    = 2 + int'(r2[19:17]) % 7;  // 8..32 bytes forward
    if (k > room) k = room;
    bof  = 13'(k * 4);
    case (r[31:28])
      4'd0: return {r2[31:12], rd, OPC_LUI};
      4'd4, 4'd5, 4'd6, 4'd7: begin
        case (r2[2:0])
          3'd0:    return {F7_ADD, rs2, rs1, F3_ADD, rd, OPC_OP};
          3'd1:    return {F7_SUB, rs2, rs1, F3_ADD, rd, OPC_OP};
          3'd2:    return {F7_ADD, rs2, rs1, F3_XOR, rd, OPC_OP};
          3'd3:    return {F7_ADD, rs2, rs1, F3_OR, rd, OPC_OP};
          default: return {F7_ADD, rs2, rs1, F3_AND, rd, OPC_OP};
        endcase
      end
      4'd8, 4'd9:   return {ofs, 5'd0, F3_LW, rd, OPC_LOAD};
      4'd10, 4'd11: return {ofs[11:5], rs2, 5'd0, F3_SW, ofs[4:0], OPC_STORE};
      4'd12, 4'd13, 4'd14, 4'd15: begin
        if (room < 2) return {r2[11:0], rs1, F3_ADD, rd, OPC_OP_IMM};  // no room to jump
        return {bof[12], bof[10:5], rs2, rs1, (r[28] ? F3_BNE : F3_BEQ),
                bof[4:1], bof[11], OPC_BRANCH};
      end
      default: return {r2[11:0], rs1, F3_ADD, rd, OPC_OP_IMM};  // addi
    endcase
  endfunction

////////////////////
// reference model
////////////////////

  // one instruction at pc_m, fills the expected record
  task automatic model_step();
    logic [31:0] ins;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] ea;
    logic [31:0] pc_nxt;
    logic        wr;
    ins    = ref_mem[pc_m[11:2]];
    rd     = ins[11:7];
    a      = regs[ins[19:15]];  // regs[0] stays zero
    b      = regs[ins[24:20]];
    val    = '0;
    wr     = 1'b0;
    pc_nxt = pc_m + 32'd4;
    exp_adr     = pc_m;
    exp_ins     = ins;
    exp_wbu_vld = 1'b0;
    exp_lsu_vld = 1'b0;
    case (ins[6:0])
      OPC_LUI: begin
        wr  = 1'b1;
        val = {ins[31:12], 12'h000};
      end
      OPC_OP_IMM: begin
        wr  = 1'b1;
        val = a + {{20{ins[31]}}, ins[31:20]};  // addi only
      end
      OPC_OP: begin
        wr = 1'b1;
        case (ins[14:12])
          F3_XOR:  val = a ^ b;
          F3_OR:   val = a | b;
          F3_AND:  val = a & b;
          default: val = ins[30] ? a - b : a + b;  // bit 30 picks sub
        endcase
      end
      OPC_LOAD: begin
        ea          = a + {{20{ins[31]}}, ins[31:20]};
        wr          = 1'b1;
        val         = ref_mem[ea[11:2]];
        exp_lsu_vld = 1'b1;
        exp_lsu_wen = 1'b0;
        exp_lsu_adr = ea;
        exp_lsu_dat = val;
      end
      OPC_STORE: begin
        ea                 = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        ref_mem[ea[11:2]]  = b;
        exp_lsu_vld        = 1'b1;
        exp_lsu_wen        = 1'b1;
        exp_lsu_adr        = ea;
        exp_lsu_dat        = b;
      end
      OPC_BRANCH: begin
        if ((ins[14:12] == F3_BNE) ? (a != b) : (a == b))
          pc_nxt = pc_m + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      default: begin
        $display("reference model found opcode %b outside the subset", ins[6:0]);
        abort_run();
      end
    endcase
    if (wr && (rd != 5'd0)) begin  // x0 never written
      exp_wbu_vld = 1'b1;
      exp_wbu_idx = rd;
      exp_wbu_dat = val;
      regs[rd]    = val;
    end
    pc_m = pc_nxt;
  endtask

  task automatic wait_record();
    int cnt;
    cnt = 0;
    @(negedge tcb);
    while (ret_vld !== 1'b1) begin
      cnt++;
      if (cnt > TMO) begin
        $display("no retire record within %0d cycles at %0t ns", TMO, $time);
        abort_run();
      end
      @(negedge tcb);
    end
  endtask

////////////////////
// bus memory
////////////////////

  // samples mid-cycle, answers 1 ns after the edge
  initial begin
    logic        trn;
    logic        hold;
    logic        h_wen;
    logic [31:0] h_adr;
    logic [31:0] h_wdt;
    logic [31:0] r;
    int          stall;
    hold  = 1'b0;
    stall = 0;
    forever begin
      @(negedge tcb);
      if (hold) begin  // stalled request must not move
        check_equal("bus_vld", 32'(bus_vld), 32'd1);
        check_equal("bus_wen", 32'(bus_wen), 32'(h_wen));
        check_equal("bus_adr", bus_adr, h_adr);
        check_equal("bus_wdt", bus_wdt, h_wdt);
      end
      trn   = (bus_vld === 1'b1) && bus_rdy;
      hold  = (bus_vld === 1'b1) && !bus_rdy;
      h_wen = bus_wen;
      h_adr = bus_adr;
      h_wdt = bus_wdt;
      if (trn && ((bus_adr[31:12] != 20'd0) || (bus_adr[1:0] != 2'b00))) begin
        $display("bus access to %h at %0t ns lies outside the word memory", bus_adr, $time);
        abort_run();
      end
      if (trn && (bus_adr == GPR_ADR)) begin
        $display("register x0 was accessed on the bus at %0t ns", $time);
        abort_run();
      end
      @(posedge tcb);
      #1;
      if (trn && h_wen) mem[h_adr[11:2]] = h_wdt;
      bus_rdt = (trn && !h_wen) ? mem[h_adr[11:2]] : next_rand();  // junk between reads
      if (stall > 0) begin
        bus_rdy = 1'b0;
        stall--;
      end else begin
        bus_rdy = 1'b1;
        r       = next_rand();
        stall   = (r[31:29] > 3'd4) ? 0 : int'(r[31:29]);  // up to 4 low cycles
      end
    end
  end

////////////////////
// main sequence
////////////////////

  initial begin
    int cnt;
    rst     = 1'b1;
    bus_rdy = 1'b0;
    bus_rdt = '0;
    pc_m    = RESET_ADR;
    for (int w = 0; w < 1024; w++) begin
      mem[w] = fill_word(10'(w));
    end
    for (int j = 0; j < 32; j++) begin
      mem[GPR_ADR[11:2] + 10'(j)] = '0;  // register file starts zeroed
      regs[j] = '0;
    end
    for (int i = 0; i < N_INS - 1; i++) begin
      mem[RESET_ADR[11:2] + 10'(i)] = random_ins(i);
    end
    mem[RESET_ADR[11:2] + 10'(N_INS - 1)] = {25'd0, OPC_BRANCH};  // beq x0,x0,0
    for (int w = 0; w < 1024; w++) begin
      ref_mem[w] = mem[w];
    end

    // quiet bus during reset
    repeat (15) begin
      @(negedge tcb);
      check_equal("bus_vld", 32'(bus_vld), 32'd0);
      check_equal("ret_vld", 32'(ret_vld), 32'd0);
    end
    @(posedge tcb);  // 16th edge with reset
    #1;
    rst = 1'b0;

    cnt = 0;
    @(negedge tcb);
    while (bus_vld !== 1'b1) begin  // first request
      check_equal("ret_vld", 32'(ret_vld), 32'd0);
      cnt++;
      if (cnt > TMO) begin
        $display("no bus request within %0d cycles after reset", TMO);
        abort_run();
      end
      @(negedge tcb);
    end
    check_equal("bus_wen", 32'(bus_wen), 32'd0);  // fetch is a read
    check_equal("bus_adr", bus_adr, RESET_ADR);

    for (int n = 0; n < N_REC; n++) begin
      wait_record();
      model_step();
      check_equal("ret_adr", ret_adr, exp_adr);
      check_equal("ret_ins", ret_ins, exp_ins);
      check_equal("ret_wbu_vld", 32'(ret_wbu_vld), 32'(exp_wbu_vld));
      if (exp_wbu_vld) begin
        check_equal("ret_wbu_idx", 32'(ret_wbu_idx), 32'(exp_wbu_idx));
        check_equal("ret_wbu_dat", ret_wbu_dat, exp_wbu_dat);
      end
      check_equal("ret_lsu_vld", 32'(ret_lsu_vld), 32'(exp_lsu_vld));
      if (exp_lsu_vld) begin
        check_equal("ret_lsu_wen", 32'(ret_lsu_wen), 32'(exp_lsu_wen));
        check_equal("ret_lsu_adr", ret_lsu_adr, exp_lsu_adr);
        check_equal("ret_lsu_dat", ret_lsu_dat, exp_lsu_dat);
      end
      // register file in memory at base + 4 * index
      for (int j = 0; j < 32; j++) begin
        check_equal($sformatf("mem gpr x%0d", j), mem[GPR_ADR[11:2] + 10'(j)], regs[j]);
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/mouse_top.sv
`timescale 1ns/1ps
`default_nettype none

module mouse_top #(
  parameter logic [31:0] RESET_ADR = 32'h0000_0000,
  parameter logic [31:0] GPR_ADR   = 32'h0000_0f80
)(
  input  logic                           tcb,
  input  logic                           rst,
  // system bus
  output logic                           bus_vld,
  output logic                           bus_wen,
  output logic [mouse_isa_pkg::XLEN-1:0] bus_adr,
  output logic [mouse_isa_pkg::XLEN-1:0] bus_wdt,
  input  logic                           bus_rdy,
  input  logic [mouse_isa_pkg::XLEN-1:0] bus_rdt,
  // retire records
  output logic                           ret_vld,
  output logic [mouse_isa_pkg::XLEN-1:0] ret_adr,
  output logic [mouse_isa_pkg::XLEN-1:0] ret_ins,
  output logic                           ret_wbu_vld,
  output logic [4:0]                     ret_wbu_idx,
  output logic [mouse_isa_pkg::XLEN-1:0] ret_wbu_dat,
  output logic                           ret_lsu_vld,
  output logic                           ret_lsu_wen,
  output logic [mouse_isa_pkg::XLEN-1:0] ret_lsu_adr,
  output logic [mouse_isa_pkg::XLEN-1:0] ret_lsu_dat
);
  import mouse_isa_pkg::*;
  import mouse_bus_pkg::*;

  pha_t            pha;
  ins_t            ins;
  op_t             op;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [2:0]      fn3;
  logic            alt;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rs1_dat;
  logic [XLEN-1:0] rs2_dat;
  logic [XLEN-1:0] res;
  logic [XLEN-1:0] mem_adr;
  logic [XLEN-1:0] nxt_pc;

  mouse_bus_if bus (.tcb (tcb), .rst (rst));

  // interface to pins
  assign bus_vld = bus.vld;
  assign bus_wen = bus.wen;
  assign bus_adr = bus.adr;
  assign bus_wdt = bus.wdt;
  assign bus.rdy = bus_rdy;
  assign bus.rdt = bus_rdt;

  mouse_decode dec (
    .ins (ins), .op (op), .rd (rd), .rs1 (rs1), .rs2 (rs2),
    .fn3 (fn3), .alt (alt), .imm (imm)
  );

  mouse_execute exe (
    .op (op), .fn3 (fn3), .alt (alt), .pc (pc), .imm (imm),
    .rs1_dat (rs1_dat), .rs2_dat (rs2_dat),
    .res (res), .mem_adr (mem_adr), .nxt_pc (nxt_pc),
    .tkn ()  // already folded into nxt_pc
  );

  mouse_control #(.RESET_ADR (RESET_ADR), .GPR_ADR (GPR_ADR)) ctl (
    .tcb (tcb), .rst (rst), .bus (bus), .pha (pha), .ins (ins),
    .op (op), .rd (rd), .rs1 (rs1), .rs2 (rs2),
    .pc (pc), .rs1_dat (rs1_dat), .rs2_dat (rs2_dat),
    .res (res), .mem_adr (mem_adr), .nxt_pc (nxt_pc)
  );

  mouse_retire #(.GPR_ADR (GPR_ADR)) ret (
    .tcb (tcb), .rst (rst), .bus (bus), .pha (pha),
    .ret_vld (ret_vld), .ret_adr (ret_adr), .ret_ins (ret_ins),
    .ret_wbu_vld (ret_wbu_vld), .ret_wbu_idx (ret_wbu_idx), .ret_wbu_dat (ret_wbu_dat),
    .ret_lsu_vld (ret_lsu_vld), .ret_lsu_wen (ret_lsu_wen),
    .ret_lsu_adr (ret_lsu_adr), .ret_lsu_dat (ret_lsu_dat)
  );

endmodule

`default_nettype wire

//--- logic/mouse_retire.sv
`timescale 1ns/1ps
`default_nettype none

module mouse_retire #(
  parameter logic [31:0] GPR_ADR = 32'h0000_0f80
)(
  input  logic                           tcb,
  input  logic                           rst,
  mouse_bus_if.mon                       bus,
  input  mouse_bus_pkg::pha_t            pha,
  output logic                           ret_vld,      // one pulse per record
  output logic [mouse_isa_pkg::XLEN-1:0] ret_adr,      // pc
  output logic [mouse_isa_pkg::XLEN-1:0] ret_ins,
  output logic                           ret_wbu_vld,
  output logic [4:0]                     ret_wbu_idx,
  output logic [mouse_isa_pkg::XLEN-1:0] ret_wbu_dat,
  output logic                           ret_lsu_vld,
  output logic                           ret_lsu_wen,
  output logic [mouse_isa_pkg::XLEN-1:0] ret_lsu_adr,
  output logic [mouse_isa_pkg::XLEN-1:0] ret_lsu_dat   // load or store data
);
  import mouse_isa_pkg::*;
  import mouse_bus_pkg::*;

  // request side of the last transfer
  pha_t            pha_q;
  logic            wen_q;
  logic [XLEN-1:0] adr_q;
  logic [XLEN-1:0] wdt_q;
  // record under construction
  logic            cur_vld;  // a fetch was seen
  logic [XLEN-1:0] cur_adr;
  logic [XLEN-1:0] cur_ins;
  logic            wbu_vld;
  logic [4:0]      wbu_idx;
  logic [XLEN-1:0] wbu_dat;
  logic            lsu_vld;
  logic            lsu_wen;
  logic [XLEN-1:0] lsu_adr;
  logic [XLEN-1:0] lsu_dat;
  logic            fch;      // fetch data arrives

  assign fch = bus.rsp && (pha_q == PHA_IF);

  always_ff @(posedge tcb) begin
    if (bus.trn) begin
      pha_q <= pha;
      wen_q <= bus.wen;
      adr_q <= bus.adr;
      wdt_q <= bus.wdt;
    end
  end

////////////////////
// record gathering
////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      cur_vld <= 1'b0;
      wbu_vld <= 1'b0;
      lsu_vld <= 1'b0;
    end else if (bus.rsp) begin
      case (pha_q)
        PHA_IF: begin
          cur_vld <= 1'b1;
          wbu_vld <= 1'b0;  // new instruction, start clean
          lsu_vld <= 1'b0;
        end
        PHA_WB:           wbu_vld <= 1'b1;
        PHA_MLD, PHA_MST: lsu_vld <= 1'b1;
        default: ;  // source reads are not recorded
      endcase
    end
  end

  always_ff @(posedge tcb) begin
    if (bus.rsp) begin
      case (pha_q)
        PHA_IF: begin
          cur_adr <= adr_q;
          cur_ins <= bus.rdt;
        end
        PHA_WB: begin
          wbu_idx <= gpr_idx(GPR_ADR, adr_q);
          wbu_dat <= wdt_q;
        end
        PHA_MLD, PHA_MST: begin
          lsu_wen <= wen_q;
          lsu_adr <= adr_q;
          lsu_dat <= wen_q ? wdt_q : bus.rdt;
        end
        default: ;
      endcase
    end
  end

////////////////////
// record output
////////////////////

  always_ff @(posedge tcb) begin
    if (rst) begin
      ret_vld     <= 1'b0;
      ret_wbu_vld <= 1'b0;
      ret_lsu_vld <= 1'b0;
    end else begin
      ret_vld <= fch && cur_vld;  // first fetch has no predecessor
      if (fch) begin
        ret_wbu_vld <= wbu_vld;
        ret_lsu_vld <= lsu_vld;
      end
    end
  end

  always_ff @(posedge tcb) begin
    if (fch) begin
      ret_adr     <= cur_adr;
      ret_ins     <= cur_ins;
      ret_wbu_idx <= wbu_idx;
      ret_wbu_dat <= wbu_dat;
      ret_lsu_wen <= lsu_wen;
      ret_lsu_adr <= lsu_adr;
      ret_lsu_dat <= lsu_dat;
    end
  end

endmodule

`default_nettype wire

//--- logic/mouse_control.sv
`timescale 1ns/1ps
`default_nettype none

module mouse_control #(
  parameter logic [31:0] RESET_ADR = 32'h0000_0000,
  parameter logic [31:0] GPR_ADR   = 32'h0000_0f80
)(
  input  logic                           tcb,
  input  logic                           rst,
  mouse_bus_if.man                       bus,
  output mouse_bus_pkg::pha_t            pha,
  output mouse_isa_pkg::ins_t            ins,      // word seen by decode
  // decode fields
  input  mouse_isa_pkg::op_t             op,
  input  logic [4:0]                     rd,
  input  logic [4:0]                     rs1,
  input  logic [4:0]                     rs2,
  // execute operands and results
  output logic [mouse_isa_pkg::XLEN-1:0] pc,
  output logic [mouse_isa_pkg::XLEN-1:0] rs1_dat,
  output logic [mouse_isa_pkg::XLEN-1:0] rs2_dat,
  input  logic [mouse_isa_pkg::XLEN-1:0] res,
  input  logic [mouse_isa_pkg::XLEN-1:0] mem_adr,
  input  logic [mouse_isa_pkg::XLEN-1:0] nxt_pc
);
  import mouse_isa_pkg::*;
  import mouse_bus_pkg::*;

  logic            req;    // request pending, low while waiting for data
  ins_t            ins_q;  // fetched instruction
  logic [XLEN-1:0] rs1_q;
  logic [XLEN-1:0] rs2_q;
  logic [XLEN-1:0] ld_q;   // load data for write-back
  logic            need_rs1;
  logic            need_rs2;
  logic            need_wb;
  pha_t            pha_nxt;
  logic            wen;
  logic [XLEN-1:0] adr;
  logic [XLEN-1:0] wdt;

////////////////////
// operands
////////////////////

  // during the fetch data cycle decode sees the bus word directly
  assign ins = (pha == PHA_IF) ? ins_t'(bus.rdt) : ins_q;

  // x0 reads as zero, fresh read data bypasses the latch
  assign rs1_dat = (rs1 == 5'd0) ? '0 : (pha == PHA_RS1) ? bus.rdt : rs1_q;
  assign rs2_dat = (rs2 == 5'd0) ? '0 : (pha == PHA_RS2) ? bus.rdt : rs2_q;

  always_ff @(posedge tcb) begin
    if (bus.rsp) begin
      case (pha)
        PHA_IF:  ins_q <= ins_t'(bus.rdt);
        PHA_RS1: rs1_q <= bus.rdt;
        PHA_RS2: rs2_q <= bus.rdt;
        PHA_MLD: ld_q  <= bus.rdt;
        default: ;  // writes return nothing
      endcase
    end
  end

////////////////////
// phase sequencer
////////////////////

  assign need_rs1 = (op != OP_LUI) && (rs1 != 5'd0);
  assign need_rs2 = (op inside {OP_ALU, OP_STORE, OP_BRANCH}) && (rs2 != 5'd0);
  assign need_wb  = (op inside {OP_LUI, OP_ALUI, OP_ALU, OP_LOAD}) && (rd != 5'd0);

  // pick the first remaining phase after the current one
  always_comb begin
    pha_nxt = PHA_IF;  // nothing left, instruction done
    if ((pha == PHA_IF) && need_rs1)
      pha_nxt = PHA_RS1;
    else if ((pha inside {PHA_IF, PHA_RS1}) && need_rs2)
      pha_nxt = PHA_RS2;
    else if ((pha inside {PHA_IF, PHA_RS1, PHA_RS2}) && (op == OP_LOAD))
      pha_nxt = PHA_MLD;
    else if ((pha inside {PHA_IF, PHA_RS1, PHA_RS2}) && (op == OP_STORE))
      pha_nxt = PHA_MST;
    else if ((pha inside {PHA_IF, PHA_RS1, PHA_RS2, PHA_MLD}) && need_wb)
      pha_nxt = PHA_WB;
  end

  always_ff @(posedge tcb) begin
    if (rst) begin
      req <= 1'b0;
      pha <= PHA_IF;
      pc  <= RESET_ADR;
    end else if (req) begin
      if (bus.trn) req <= 1'b0;  // hold until accepted
    end else begin
      req <= 1'b1;  // one wait cycle, then next request
      if (bus.rsp) begin
        pha <= pha_nxt;
        if (pha_nxt == PHA_IF) pc <= nxt_pc;  // retire, branch resolved here
      end
    end
  end

////////////////////
// bus request
////////////////////

  always_comb begin
    wen = 1'b0;
    adr = pc;  // fetch
    wdt = '0;
    case (pha)
      PHA_RS1: adr = gpr_adr(GPR_ADR, rs1);
      PHA_RS2: adr = gpr_adr(GPR_ADR, rs2);
      PHA_MLD: adr = mem_adr;
      PHA_MST: begin
        wen = 1'b1;
        adr = mem_adr;
        wdt = rs2_dat;
      end
      PHA_WB: begin
        wen = 1'b1;
        adr = gpr_adr(GPR_ADR, rd);
        wdt = (op == OP_LOAD) ? ld_q : res;
      end
      default: ;
    endcase
  end

  assign bus.vld = req;
  assign bus.wen = wen;
  assign bus.adr = adr;
  assign bus.wdt = wdt;

endmodule

`default_nettype wire

//--- logic/mouse_execute.sv
`timescale 1ns/1ps
`default_nettype none

module mouse_execute (
  input  mouse_isa_pkg::op_t             op,
  input  logic [2:0]                     fn3,
  input  logic                           alt,
  input  logic [mouse_isa_pkg::XLEN-1:0] pc,
  input  logic [mouse_isa_pkg::XLEN-1:0] imm,
  input  logic [mouse_isa_pkg::XLEN-1:0] rs1_dat,
  input  logic [mouse_isa_pkg::XLEN-1:0] rs2_dat,
  output logic [mouse_isa_pkg::XLEN-1:0] res,      // write-back value
  output logic [mouse_isa_pkg::XLEN-1:0] mem_adr,  // load/store address
  output logic [mouse_isa_pkg::XLEN-1:0] nxt_pc,
  output logic                           tkn       // branch taken
);
  import mouse_isa_pkg::*;

  logic [XLEN-1:0] opb;  // second alu operand
  logic            sub;
  logic            eql;

  assign opb = (op == OP_ALU) ? rs2_dat : imm;
  assign sub = (op == OP_ALU) && alt;  // addi has no sub form

  // alu
  always_comb begin
    case (fn3)
      F3_XOR:  res = rs1_dat ^ opb;
      F3_OR:   res = rs1_dat | opb;
      F3_AND:  res = rs1_dat & opb;
      default: res = sub ? rs1_dat - opb : rs1_dat + opb;
    endcase
    if (op == OP_LUI) res = imm;  // lui bypasses the alu
  end

  assign mem_adr = rs1_dat + imm;  // word access, base + offset

  // beq/bne on raw operands
  assign eql    = (rs1_dat == rs2_dat);
  assign tkn    = (op == OP_BRANCH) && ((fn3 == F3_BEQ) ? eql : !eql);
  assign nxt_pc = tkn ? pc + imm : pc + 32'd4;

endmodule

`default_nettype wire

//--- logic/mouse_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mouse_decode (
  input  mouse_isa_pkg::ins_t            ins,
  output mouse_isa_pkg::op_t             op,
  output logic [4:0]                     rd,
  output logic [4:0]                     rs1,
  output logic [4:0]                     rs2,
  output logic [2:0]                     fn3,
  output logic                           alt,  // sub select
  output logic [mouse_isa_pkg::XLEN-1:0] imm
);
  import mouse_isa_pkg::*;

  // register fields sit in the same place in both views
  assign rd  = ins.r.rd;
  assign rs1 = ins.r.rs1;
  assign rs2 = ins.r.rs2;
  assign fn3 = ins.r.funct3;
  assign alt = (ins.r.funct7 == F7_SUB);

  always_comb begin
    op  = OP_ALUI;  // unknown opcodes fall here
    imm = '0;
    case (ins.r.opcode)
      OPC_LUI: begin
        op  = OP_LUI;
        imm = {ins.r.funct7, ins.r.rs2, ins.r.rs1, ins.r.funct3, 12'h000};  // u-type
      end
      OPC_OP_IMM, OPC_LOAD: begin
        op  = (ins.r.opcode == OPC_LOAD) ? OP_LOAD : OP_ALUI;
        imm = {{20{ins.r.funct7[6]}}, ins.r.funct7, ins.r.rs2};  // i-type
      end
      OPC_OP: begin
        op  = OP_ALU;  // no immediate
      end
      OPC_STORE: begin
        op  = OP_STORE;
        imm = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};  // s-type
      end
      OPC_BRANCH: begin
        op  = OP_BRANCH;
        // b-type, bits scrambled over the s fields
        imm = {{19{ins.s.imm_hi[6]}}, ins.s.imm_hi[6], ins.s.imm_lo[0],
               ins.s.imm_hi[5:0], ins.s.imm_lo[4:1], 1'b0};
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/mouse_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mouse_bus_if (
  input logic tcb,
  input logic rst
);
  import mouse_isa_pkg::*;

  logic            vld;  // request valid
  logic            wen;  // write enable
  logic [XLEN-1:0] adr;  // byte address
  logic [XLEN-1:0] wdt;  // write data
  logic            rdy;  // ready
  logic [XLEN-1:0] rdt;  // read data, one cycle after transfer

  logic trn;  // transfer this cycle
  logic rsp;  // rdt valid this cycle

  assign trn = vld & rdy;

  always_ff @(posedge tcb) begin
    if (rst) rsp <= 1'b0;
    else     rsp <= trn;
  end

  modport man (output vld, wen, adr, wdt, input rdy, rdt, trn, rsp);
  modport mon (input vld, wen, adr, wdt, rdy, rdt, trn, rsp);

endinterface

`default_nettype wire

//--- logic/mouse_bus_pkg.sv
`default_nettype none

package mouse_bus_pkg;

  // phase codes, gpr phases share bit 2
  typedef enum logic [2:0] {
    PHA_IF  = 3'b000,  // instruction fetch
    PHA_MLD = 3'b001,  // memory load
    PHA_MST = 3'b010,  // memory store
    PHA_WB  = 3'b100,  // gpr write-back
    PHA_RS1 = 3'b101,  // gpr read rs1
    PHA_RS2 = 3'b110   // gpr read rs2
  } pha_t;

  // gpr location in memory, index in bits 6:2
  function automatic logic [31:0] gpr_adr (input logic [31:0] base, input logic [4:0] idx);
    return {base[31:7], idx, 2'b00};
  endfunction

  // recover register index from a gpr address
  function automatic logic [4:0] gpr_idx (input logic [31:0] base, input logic [31:0] adr);
    logic [31:0] ofs;
    ofs = adr - base;
    return ofs[6:2];
  endfunction

endpackage

`default_nettype wire

//--- logic/mouse_isa_pkg.sv
`default_nettype none

package mouse_isa_pkg;

  localparam int unsigned XLEN = 32;  // data and address width

////////////////////
// opcodes
////////////////////

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // addi and friends
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register alu
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3, alu
  localparam logic [2:0] F3_ADD = 3'b000;  // add/sub/addi
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  // funct3, memory (word only)
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_SW  = 3'b010;
  // funct3, branch
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // funct7
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;  // also selects sub for op

  // one word, two layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;  // alu, load, lui
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;  // store, branch
  } ins_t;

  // operation class
  typedef enum logic [2:0] {
    OP_LUI, OP_ALUI, OP_ALU, OP_LOAD, OP_STORE, OP_BRANCH
  } op_t;

endpackage

`default_nettype wire
